/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Address and line geometry
    localparam int addr_width     = 64;
    localparam int beat_width     = 64;                   // AXI beat and CPU word
    localparam int beats_per_line = 8;
    localparam int line_width     = beat_width * beats_per_line;
    localparam int offset_width   = 6;                    // Byte offset within a 64-byte line
    localparam int word_sel_width = 3;                    // Address bits 5 to 3
    localparam int sets           = 4;
    localparam int set_width      = 2;
    localparam int tag_width      = addr_width - set_width - offset_width;

    // AXI read address codes
    localparam logic [7:0] axi_len_line   = 8'd7;         // Eight beats
    localparam logic [2:0] axi_size_beat  = 3'd3;         // Eight bytes per beat
    localparam logic [1:0] axi_burst_incr = 2'd1;

    // Request address without the byte bits
    typedef struct packed {
        logic [tag_width-1:0]      tag;
        logic [set_width-1:0]      set_index;
        logic [word_sel_width-1:0] word_sel;
    } addr_fields_t;

    typedef enum logic [2:0] {
        refill_idle,
        refill_wait_port,   // Instruction cache holds the memory port
        refill_request,
        refill_receive,
        refill_install,
        refill_replay
    } refill_state_t;

    // Read address channel
    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_ar_t;

endpackage

`default_nettype wire

/* rtl/dcache_lookup.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_lookup #(
    parameter int ways = 4,
    localparam int way_width = $clog2(ways)
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              read_enable,
    input  logic [dcache_pkg::addr_width-1:0] address,
    input  logic                              replay_valid,
    input  dcache_pkg::addr_fields_t          replay_fields,
    input  logic                              install_valid,
    input  dcache_pkg::addr_fields_t          install_fields,
    input  logic [way_width-1:0]              install_way,
    output logic                              lookup_valid,
    output dcache_pkg::addr_fields_t          lookup_fields,
    output logic                              lookup_hit,
    output logic [way_width-1:0]              lookup_way
);
    dcache_pkg::addr_fields_t         cpu_fields;
    dcache_pkg::addr_fields_t         sel_fields;
    logic                             sel_valid;
    logic [ways-1:0]                  hit_vec;
    logic [way_width-1:0]             hit_way;

    logic [dcache_pkg::tag_width-1:0] tags [dcache_pkg::sets][ways];
    logic [ways-1:0]                  valid_bits [dcache_pkg::sets];

    // Byte bits 2 to 0 are dropped, every read is a full word
    assign cpu_fields.tag       = address[dcache_pkg::addr_width-1 -: dcache_pkg::tag_width];
    assign cpu_fields.set_index = address[dcache_pkg::offset_width +: dcache_pkg::set_width];
    assign cpu_fields.word_sel  = address[dcache_pkg::offset_width-1 -: dcache_pkg::word_sel_width];

    assign sel_valid  = replay_valid | read_enable;
    assign sel_fields = replay_valid ? replay_fields : cpu_fields;  // Replay wins

    // Tag compare across all ways of the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            hit_vec[w] = valid_bits[sel_fields.set_index][w] &&
                         (tags[sel_fields.set_index][w] == sel_fields.tag);
        end
        for (int w = ways - 1; w >= 0; w--) begin
            if (hit_vec[w])
                hit_way = way_width'(w);  // Lowest matching way
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lookup_valid <= 1'b0;
            lookup_hit   <= 1'b0;
        end else begin
            lookup_valid <= sel_valid;
            lookup_hit   <= sel_valid && (|hit_vec);
        end
        lookup_fields <= sel_fields;
        lookup_way    <= hit_way;
    end

    // Tag and valid update on install
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < dcache_pkg::sets; s++)
                valid_bits[s] <= '0;
        end else if (install_valid) begin
            valid_bits[install_fields.set_index][install_way] <= 1'b1;
        end
        if (install_valid)
            tags[install_fields.set_index][install_way] <= install_fields.tag;
    end

endmodule

`default_nettype wire

/* rtl/dcache_data.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_data #(
    parameter int ways = 4,
    localparam int way_width = $clog2(ways)
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              lookup_valid,
    input  logic                              lookup_hit,
    input  logic [way_width-1:0]              lookup_way,
    input  dcache_pkg::addr_fields_t          lookup_fields,
    input  logic                              install_valid,
    input  dcache_pkg::addr_fields_t          install_fields,
    input  logic [way_width-1:0]              install_way,
    input  logic [dcache_pkg::line_width-1:0] install_line,
    output logic [dcache_pkg::beat_width-1:0] data,
    output logic                              send_enable
);
    logic [dcache_pkg::line_width-1:0] lines [dcache_pkg::sets][ways];
    logic [dcache_pkg::line_width-1:0] hit_line;
    logic                              read_hit;

    assign read_hit = lookup_valid && lookup_hit;
    assign hit_line = lines[lookup_fields.set_index][lookup_way];

    always_ff @(posedge clock) begin
        if (reset)
            send_enable <= 1'b0;
        else
            send_enable <= read_hit;  // One pulse per hit
    end

    // Word select out of the hit line
    always_ff @(posedge clock) begin
        if (read_hit)
            data <= hit_line[lookup_fields.word_sel * dcache_pkg::beat_width +:
                             dcache_pkg::beat_width];
    end

    // Whole line written on install
    always_ff @(posedge clock) begin
        if (install_valid)
            lines[install_fields.set_index][install_way] <= install_line;
    end

endmodule

`default_nettype wire

/* rtl/dcache_refill.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_refill #(
    parameter int ways = 4,
    localparam int way_width = $clog2(ways)
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              lookup_valid,
    input  logic                              lookup_hit,
    input  dcache_pkg::addr_fields_t          lookup_fields,
    input  logic                              instruction_cache_reading,
    input  logic                              m_axi_arready,
    input  logic                              m_axi_rvalid,
    input  logic                              m_axi_rlast,
    input  logic [dcache_pkg::beat_width-1:0] m_axi_rdata,
    output dcache_pkg::axi_ar_t               ar,
    output logic                              m_axi_rready,
    output logic                              data_cache_reading,
    output logic                              install_valid,
    output dcache_pkg::addr_fields_t          install_fields,
    output logic [way_width-1:0]              install_way,
    output logic [dcache_pkg::line_width-1:0] install_line,
    output logic                              replay_valid,
    output dcache_pkg::addr_fields_t          replay_fields
);
    dcache_pkg::refill_state_t         state;
    dcache_pkg::refill_state_t         state_next;
    dcache_pkg::addr_fields_t          miss_fields;
    logic [dcache_pkg::line_width-1:0] line_buf;
    logic [ways-1:0]                   valid_copy [dcache_pkg::sets];
    logic [way_width-1:0]              rr_ptr;
    logic [way_width-1:0]              victim_way;
    logic                              set_full;
    logic                              beat;

    assign beat = m_axi_rready && m_axi_rvalid;

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::refill_idle:
                if (lookup_valid && !lookup_hit)
                    state_next = instruction_cache_reading ? dcache_pkg::refill_wait_port
                                                           : dcache_pkg::refill_request;
            dcache_pkg::refill_wait_port:
                if (!instruction_cache_reading)
                    state_next = dcache_pkg::refill_request;
            dcache_pkg::refill_request:
                if (m_axi_arready)
                    state_next = dcache_pkg::refill_receive;
            dcache_pkg::refill_receive:
                if (beat && m_axi_rlast)
                    state_next = dcache_pkg::refill_install;
            dcache_pkg::refill_install: state_next = dcache_pkg::refill_replay;
            default:                    state_next = dcache_pkg::refill_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= dcache_pkg::refill_idle;
        else
            state <= state_next;
    end

    always_ff @(posedge clock) begin
        if (state == dcache_pkg::refill_idle && lookup_valid && !lookup_hit)
            miss_fields <= lookup_fields;
        if (beat)
            line_buf <= {m_axi_rdata, line_buf[dcache_pkg::line_width-1:dcache_pkg::beat_width]};
    end

    // Lowest invalid way first, otherwise the round-robin way
    always_comb begin
        set_full   = &valid_copy[miss_fields.set_index];
        victim_way = rr_ptr;
        for (int w = ways - 1; w >= 0; w--) begin
            if (!valid_copy[miss_fields.set_index][w])
                victim_way = way_width'(w);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rr_ptr <= '0;
            for (int s = 0; s < dcache_pkg::sets; s++)
                valid_copy[s] <= '0;
        end else if (install_valid) begin
            valid_copy[miss_fields.set_index][victim_way] <= 1'b1;
            if (set_full)  // Pointer moves only on an eviction
                rr_ptr <= (rr_ptr == way_width'(ways - 1)) ? '0 : rr_ptr + 1'b1;
        end
    end

    // Line-aligned INCR burst for the missing line
    always_comb begin
        ar.valid = (state == dcache_pkg::refill_request);
        ar.addr  = {miss_fields.tag, miss_fields.set_index, {dcache_pkg::offset_width{1'b0}}};
        ar.len   = dcache_pkg::axi_len_line;
        ar.size  = dcache_pkg::axi_size_beat;
        ar.burst = dcache_pkg::axi_burst_incr;
    end

    assign m_axi_rready       = (state == dcache_pkg::refill_receive);
    assign data_cache_reading = (state == dcache_pkg::refill_request) || m_axi_rready;

    assign install_valid  = (state == dcache_pkg::refill_install);
    assign install_fields = miss_fields;
    assign install_way    = victim_way;
    assign install_line   = line_buf;
    assign replay_valid   = (state == dcache_pkg::refill_replay);  // Cycle after install
    assign replay_fields  = miss_fields;

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
    parameter int ways = 4
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              read_enable,
    input  logic [dcache_pkg::addr_width-1:0] address,
    input  logic                              m_axi_arready,
    input  logic                              m_axi_rvalid,
    input  logic                              m_axi_rlast,
    input  logic [dcache_pkg::beat_width-1:0] m_axi_rdata,
    input  logic                              instruction_cache_reading,
    output logic                              m_axi_arvalid,
    output logic [dcache_pkg::addr_width-1:0] m_axi_araddr,
    output logic [7:0]                        m_axi_arlen,
    output logic [2:0]                        m_axi_arsize,
    output logic [1:0]                        m_axi_arburst,
    output logic                              m_axi_rready,
    output logic [dcache_pkg::beat_width-1:0] data,
    output logic                              send_enable,
    output logic                              data_cache_reading
);
    localparam int way_width = $clog2(ways);

    logic                              lookup_valid;
    logic                              lookup_hit;
    logic [way_width-1:0]              lookup_way;
    dcache_pkg::addr_fields_t          lookup_fields;
    logic                              install_valid;
    logic [way_width-1:0]              install_way;
    dcache_pkg::addr_fields_t          install_fields;
    logic [dcache_pkg::line_width-1:0] install_line;
    logic                              replay_valid;
    dcache_pkg::addr_fields_t          replay_fields;
    dcache_pkg::axi_ar_t               ar;

    dcache_lookup #(.ways(ways)) i_lookup (
        .clock, .reset, .read_enable, .address,
        .replay_valid, .replay_fields,
        .install_valid, .install_fields, .install_way,
        .lookup_valid, .lookup_fields, .lookup_hit, .lookup_way
    );

    dcache_data #(.ways(ways)) i_data (
        .clock, .reset, .lookup_valid, .lookup_hit, .lookup_way, .lookup_fields,
        .install_valid, .install_fields, .install_way, .install_line,
        .data, .send_enable
    );

    dcache_refill #(.ways(ways)) i_refill (
        .clock, .reset, .lookup_valid, .lookup_hit, .lookup_fields,
        .instruction_cache_reading, .m_axi_arready, .m_axi_rvalid, .m_axi_rlast, .m_axi_rdata,
        .ar, .m_axi_rready, .data_cache_reading,
        .install_valid, .install_fields, .install_way, .install_line,
        .replay_valid, .replay_fields
    );

    // AR channel fields onto the bus ports
    assign m_axi_arvalid = ar.valid;
    assign m_axi_araddr  = ar.addr;
    assign m_axi_arlen   = ar.len;
    assign m_axi_arsize  = ar.size;
    assign m_axi_arburst = ar.burst;

endmodule

`default_nettype wire

/* bench/dcache_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_chk (
    input logic                      clock,
    input logic                      reset,
    input dcache_pkg::refill_state_t state,
    input dcache_pkg::axi_ar_t       ar,
    input logic                      m_axi_arready,
    input logic                      m_axi_rvalid,
    input logic                      m_axi_rlast,
    input logic                      m_axi_rready,
    input logic                      instruction_cache_reading
);
    // AR fields hold until the slave takes them
    ar_stable: assert property (@(posedge clock) disable iff (reset)
        ar.valid && !m_axi_arready |=> $stable(ar))
        else $error("AR channel changed before arready");

    // Receive window opens only after an accepted AR
    rready_after_ar: assert property (@(posedge clock) disable iff (reset)
        $rose(m_axi_rready) |-> $past(ar.valid && m_axi_arready))
        else $error("rready raised without an accepted read address");

    rready_ends_on_last: assert property (@(posedge clock) disable iff (reset)
        m_axi_rready && m_axi_rvalid && m_axi_rlast |=> !m_axi_rready)
        else $error("rready still high after the last beat");

    no_ar_on_busy_port: assert property (@(posedge clock) disable iff (reset)
        state == dcache_pkg::refill_idle && instruction_cache_reading |=> !ar.valid)
        else $error("arvalid raised while the instruction cache holds the port");

endmodule

bind dcache_refill dcache_chk i_chk (
    .clock, .reset, .state, .ar, .m_axi_arready,
    .m_axi_rvalid, .m_axi_rlast, .m_axi_rready, .instruction_cache_reading
);

`default_nettype wire

/* bench/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;
    localparam int ways           = 4;
    localparam int table_len      = 16;
    localparam int timeout_cycles = table_len * 100;
    localparam int ic_cycles      = 5;  // Instruction cache keeps the port this long
    localparam logic [63:0] pattern_key = 64'h5a5a_c3c3_0f0f_9696;

    typedef struct packed {
        logic [63:0] addr;
        logic        ic_hold;
        logic        miss;
        logic [63:0] ar_addr;
    } row_t;

    logic                              clock = 1'b0;
    logic                              reset;
    logic                              read_enable;
    logic [dcache_pkg::addr_width-1:0] address;
    logic                              instruction_cache_reading;
    logic                              m_axi_arready = 1'b0;
    logic                              m_axi_rvalid  = 1'b0;
    logic                              m_axi_rlast   = 1'b0;
    logic [dcache_pkg::beat_width-1:0] m_axi_rdata   = '0;
    logic                              m_axi_arvalid;
    logic [dcache_pkg::addr_width-1:0] m_axi_araddr;
    logic [7:0]                        m_axi_arlen;
    logic [2:0]                        m_axi_arsize;
    logic [1:0]                        m_axi_arburst;
    logic                              m_axi_rready;
    logic [dcache_pkg::beat_width-1:0] data;
    logic                              send_enable;
    logic                              data_cache_reading;

    row_t                rows [table_len];
    dcache_pkg::axi_ar_t ar_log [$];    // Every accepted AR, in order
    dcache_pkg::axi_ar_t seen_ar;
    logic [63:0]         burst_addr = '0;
    int                  beat_idx = 8;  // 8 means no burst open
    logic [7:0]          lfsr = 8'd61;
    logic                ar_fire = 1'b0;
    logic                r_fire = 1'b0;
    int                  mismatches = 0;
    int                  failures = 0;
    int                  cycles = 0;

    // Reference model of the tag store
    logic [57:0]         model_line [4][ways];
    logic                model_valid [4][ways];
    logic [1:0]          model_rr;

    always #2 clock = ~clock;

    dcache_top #(.ways(ways)) i_dut (.*);

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic check_word(input string name, input logic [dcache_pkg::beat_width-1:0] got,
                              input logic [dcache_pkg::beat_width-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_ar(input string name, input dcache_pkg::axi_ar_t got,
                            input dcache_pkg::axi_ar_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_idle();
        check_flag("send_enable", send_enable, 1'b0);
        check_flag("m_axi_arvalid", m_axi_arvalid, 1'b0);
        check_flag("m_axi_rready", m_axi_rready, 1'b0);
        check_flag("data_cache_reading", data_cache_reading, 1'b0);
    endtask

    // Runs one access through the model and stores the row with its expectations
    task automatic add_row(input int r, input logic [63:0] addr, input logic ic_hold);
        logic [1:0] set;
        logic [1:0] way;
        logic       hit;
        logic       free;
        set  = addr[7:6];
        hit  = 1'b0;
        free = 1'b0;
        for (int w = 0; w < ways; w++)
            hit |= model_valid[set][w] && (model_line[set][w] == addr[63:6]);
        for (int w = ways - 1; w >= 0; w--) begin
            if (!model_valid[set][w]) begin
                way  = 2'(w);  // Lowest free way wins
                free = 1'b1;
            end
        end
        if (!hit) begin
            if (!free) begin
                way      = model_rr;
                model_rr = (model_rr == 2'(ways - 1)) ? 2'd0 : model_rr + 2'd1;
            end
            model_valid[set][way] = 1'b1;
            model_line[set][way]  = addr[63:6];
        end
        rows[r] = '{addr, ic_hold, !hit, {addr[63:6], 6'b0}};
    endtask

    task automatic build_table();
        model_rr = 2'd0;
        for (int s = 0; s < 4; s++)
            for (int w = 0; w < ways; w++)
                model_valid[s][w] = 1'b0;
        add_row(0,  64'h1000, 1'b0);  // Cold miss in set 0
        add_row(1,  64'h1038, 1'b0);
        add_row(2,  64'h2008, 1'b0);
        add_row(3,  64'h3010, 1'b0);
        add_row(4,  64'h4020, 1'b0);  // Set 0 now full
        add_row(5,  64'h5028, 1'b0);  // First eviction
        add_row(6,  64'h1000, 1'b0);
        add_row(7,  64'h3030, 1'b0);
        add_row(8,  64'h5000, 1'b0);
        add_row(9,  64'h2000, 1'b0);
        add_row(10, 64'h1040, 1'b1);
        add_row(11, 64'h2088, 1'b1);
        add_row(12, 64'h1048, 1'b0);
        add_row(13, 64'h3000, 1'b0);
        add_row(14, 64'h4010, 1'b0);  // Pointer has wrapped
        add_row(15, 64'hffff_ffff_ffff_fff8, 1'b1);
    endtask

    // Handshakes seen here complete at the next rising edge
    always @(negedge clock) begin
        ar_fire = m_axi_arvalid && m_axi_arready;
        r_fire  = m_axi_rvalid && m_axi_rready;
        if (ar_fire) begin
            seen_ar.valid = m_axi_arvalid;
            seen_ar.addr  = m_axi_araddr;
            seen_ar.len   = m_axi_arlen;
            seen_ar.size  = m_axi_arsize;
            seen_ar.burst = m_axi_arburst;
            ar_log.push_back(seen_ar);
            burst_addr = m_axi_araddr;
        end
    end

    // Memory slave with random ready and valid gaps
    always @(posedge clock) begin
        #1;
        if (reset) begin
            beat_idx      = 8;
            m_axi_arready = 1'b0;
            m_axi_rvalid  = 1'b0;
        end else begin
            if (ar_fire)
                beat_idx = 0;
            if (r_fire)
                beat_idx++;
            lfsr          = lfsr_step(lfsr);
            m_axi_arready = lfsr[0];
            if (beat_idx >= 8) begin
                m_axi_rvalid = 1'b0;
            end else if (!m_axi_rvalid || r_fire) begin  // Valid holds until taken
                lfsr         = lfsr_step(lfsr);
                m_axi_rvalid = lfsr[0];
            end
            m_axi_rdata = (burst_addr + 64'(beat_idx * 8)) ^ pattern_key;
            m_axi_rlast = (beat_idx == 7);
        end
    end

    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: no response from the cache after %0d cycles", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int                  edges;
        int                  ar_base;
        int                  n_ar;
        logic                got;
        dcache_pkg::axi_ar_t exp_ar;
        reset                     = 1'b1;
        read_enable               = 1'b0;
        address                   = '0;
        instruction_cache_reading = 1'b0;
        build_table();
        repeat (10) begin
            @(posedge clock);
            #1;
            check_idle();
        end
        reset = 1'b0;
        @(negedge clock);
        check_idle();

        for (int r = 0; r < table_len; r++) begin
            @(posedge clock);
            #1;
            ar_base                   = ar_log.size();
            read_enable               = 1'b1;
            address                   = rows[r].addr;
            instruction_cache_reading = rows[r].ic_hold;
            @(posedge clock);
            #1;
            read_enable = 1'b0;
            edges       = 1;
            got         = 1'b0;
            while (!got) begin
                @(negedge clock);
                got = send_enable;
                if (edges <= 2 || !rows[r].miss)  // A hit answers exactly 2 cycles on
                    check_flag("send_enable", send_enable, !rows[r].miss && edges == 2);
                if (m_axi_arvalid) begin
                    check_flag("data_cache_reading", data_cache_reading, 1'b1);
                    if (instruction_cache_reading) begin
                        $display("error at %0t: AR issued while the port is taken", $time);
                        failures++;
                    end
                end
                if (!got) begin
                    @(posedge clock);
                    #1;
                    edges++;
                    if (edges == ic_cycles)
                        instruction_cache_reading = 1'b0;
                end
            end
            instruction_cache_reading = 1'b0;

            check_word("data", data, {rows[r].addr[63:3], 3'b000} ^ pattern_key);
            n_ar = ar_log.size() - ar_base;
            check_flag("miss", n_ar != 0, rows[r].miss);
            if (n_ar > 1) begin
                $display("error at %0t: %0d AR requests for a single read", $time, n_ar);
                failures++;
            end
            if (n_ar != 0 && rows[r].miss) begin
                exp_ar.valid = 1'b1;
                exp_ar.addr  = rows[r].ar_addr;
                exp_ar.len   = 8'd7;  // Eight beats
                exp_ar.size  = 3'd3;  // Eight bytes
                exp_ar.burst = 2'd1;  // INCR
                check_ar("ar", ar_log[ar_base], exp_ar);
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/dcache_pkg.sv
rtl/dcache_lookup.sv
rtl/dcache_data.sv
rtl/dcache_refill.sv
rtl/dcache_top.sv
bench/dcache_chk.sv
bench/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f src.f -o dcache_sim

status=0
output=$(./obj_dir/dcache_sim 2>&1) || status=$?
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
